// ==== hdl/rv_ctrl_gen.sv ====
`timescale 1ns/100ps

`include "rv_consts.svh"

module rv_ctrl_gen
    import rv_pkg::*;
(
    input  word_t    i_instruction,

    input  logic     i_grp_load,
    input  logic     i_grp_store,
    input  logic     i_grp_op_imm,
    input  logic     i_grp_op,
    input  logic     i_lui,
    input  logic     i_auipc,
    input  logic     i_jal,
    input  logic     i_jalr,
    input  logic     i_grp_branch,
    input  logic     i_grp_sys,
    input  logic     i_sra,

    output reg_idx_t o_rs1,
    output reg_idx_t o_rs2,
    output reg_idx_t o_rd,
    output funct3_t  o_funct3,

    output alu_res_t o_alu_res,
    output logic     o_add_override,
    output logic     o_op1_inv,
    output logic     o_op2_inverse,
    output logic     o_op1_src,
    output op2_src_t o_op2_src,
    output res_src_t o_res_src,
    output logic     o_reg_write,

    output csr_idx_t o_csr_idx,
    output reg_idx_t o_csr_imm,
    output logic     o_csr_imm_sel,
    output csr_op_t  o_csr_op
);

    funct3_t funct3;
    logic    alu_op;
    logic    slt_type;
    logic    pc_rel;

    assign funct3   = i_instruction[14:12];
    assign alu_op   = i_grp_op | i_grp_op_imm;
    assign slt_type = alu_op & (funct3[2:1] == 2'b01);
    // address or constant formed by a plain add
    assign pc_rel   = i_lui | i_auipc | i_jal | i_grp_load | i_grp_store;

    assign o_rs1    = i_lui ? '0 : i_instruction[19:15];
    assign o_rs2    = i_instruction[24:20];
    assign o_rd     = i_instruction[11:7];
    assign o_funct3 = funct3;

    always_comb
    begin
        o_alu_res = ALU_ARITH;
        if (i_grp_branch)
        begin
            o_alu_res = ALU_CMP;
        end
        else if (alu_op)
        begin
            case (funct3)
                `RV_F3_SLL, `RV_F3_SR:               o_alu_res = ALU_SHIFT;
                `RV_F3_SLT, `RV_F3_SLTU:             o_alu_res = ALU_CMP;
                `RV_F3_XOR, `RV_F3_OR, `RV_F3_AND:   o_alu_res = ALU_BITS;
                default:                             o_alu_res = ALU_ARITH;
            endcase
        end
    end

    assign o_add_override = pc_rel;
    // inverted compare for bne/bge/bgeu
    assign o_op1_inv      = i_grp_branch & funct3[0];

    assign o_op2_inverse = (i_grp_branch | slt_type | i_sra) ? 1'b1 :
                           (pc_rel | i_grp_op_imm)           ? 1'b0 :
                                                               i_instruction[30];

    assign o_op1_src = i_auipc | i_jal;

    assign o_op2_src = i_jal ? OP2_JIMM :
                       (i_jalr | i_grp_load | i_grp_op_imm | i_lui |
                        i_auipc | i_grp_store) ? OP2_IMM :
                       OP2_REG;

    assign o_res_src = i_grp_load       ? RES_MEM     :
                       (i_jal | i_jalr) ? RES_PC_NEXT :
                                          RES_ALU;

    assign o_reg_write = (i_instruction[1:0] == `RV_OPC_DET) & !(i_grp_branch | i_grp_store);

    assign o_csr_idx     = i_instruction[31:20];
    assign o_csr_imm     = i_instruction[19:15];
    assign o_csr_imm_sel = funct3[2];
    assign o_csr_op      = (i_grp_sys & (funct3 != `RV_F3_PRIV)) ? csr_op_t'(funct3[1:0]) :
                                                                  CSR_NONE;

endmodule

// ==== hdl/rv_decode.sv ====
`timescale 1ns/100ps

module rv_decode
    import rv_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  logic     i_flush,

    input  logic     i_valid,
    output logic     o_ready,
    input  word_t    i_instruction,
    input  pc_t      i_pc,
    input  logic     i_branch_pred,

    output logic     o_valid,
    input  logic     i_ready,
    output pc_t      o_pc,
    output pc_t      o_pc_next,
    output logic     o_branch_pred,

    output reg_idx_t o_rs1,
    output reg_idx_t o_rs2,
    output reg_idx_t o_rd,
    output funct3_t  o_funct3,
    output word_t    o_imm_i,
    output word_t    o_imm_j,

    output alu_res_t o_alu_res,
    output logic     o_add_override,
    output logic     o_op1_inv,
    output logic     o_op2_inverse,
    output logic     o_op1_src,
    output op2_src_t o_op2_src,
    output res_src_t o_res_src,
    output logic     o_reg_write,

    output csr_idx_t o_csr_idx,
    output reg_idx_t o_csr_imm,
    output logic     o_csr_imm_sel,
    output csr_op_t  o_csr_op,
    output logic     o_csr_req,
    output logic     o_csr_ebreak,

    output logic     o_inst_jal,
    output logic     o_inst_jalr,
    output logic     o_inst_branch,
    output logic     o_inst_store,
    output logic     o_inst_mret,
    output logic     o_inst_ecall,
    output logic     o_inst_supported
);

    word_t instruction;
    logic  grp_load;
    logic  grp_op_imm;
    logic  grp_op;
    logic  lui;
    logic  auipc;
    logic  grp_sys;
    logic  sra;

    rv_decode_reg u_reg
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_flush        (i_flush),
        .i_valid        (i_valid),
        .o_ready        (o_ready),
        .i_instruction  (i_instruction),
        .i_pc           (i_pc),
        .i_branch_pred  (i_branch_pred),
        .o_valid        (o_valid),
        .i_ready        (i_ready),
        .o_instruction  (instruction),
        .o_pc           (o_pc),
        .o_pc_next      (o_pc_next),
        .o_branch_pred  (o_branch_pred)
    );

    rv_inst_class u_class
    (
        .i_instruction    (instruction),
        .o_grp_load       (grp_load),
        .o_grp_store      (o_inst_store),
        .o_grp_op_imm     (grp_op_imm),
        .o_grp_op         (grp_op),
        .o_lui            (lui),
        .o_auipc          (auipc),
        .o_jal            (o_inst_jal),
        .o_jalr           (o_inst_jalr),
        .o_grp_branch     (o_inst_branch),
        .o_grp_sys        (grp_sys),
        .o_sra            (sra),
        .o_ecall          (o_inst_ecall),
        .o_ebreak         (o_csr_ebreak),
        .o_mret           (o_inst_mret),
        .o_csr_req        (o_csr_req),
        .o_inst_supported (o_inst_supported)
    );

    rv_imm_gen u_imm
    (
        .i_instruction  (instruction),
        .i_lui          (lui),
        .i_auipc        (auipc),
        .i_jal          (o_inst_jal),
        .i_grp_store    (o_inst_store),
        .o_imm_i        (o_imm_i),
        .o_imm_j        (o_imm_j)
    );

    rv_ctrl_gen u_ctrl
    (
        .i_instruction  (instruction),
        .i_grp_load     (grp_load),
        .i_grp_store    (o_inst_store),
        .i_grp_op_imm   (grp_op_imm),
        .i_grp_op       (grp_op),
        .i_lui          (lui),
        .i_auipc        (auipc),
        .i_jal          (o_inst_jal),
        .i_jalr         (o_inst_jalr),
        .i_grp_branch   (o_inst_branch),
        .i_grp_sys      (grp_sys),
        .i_sra          (sra),
        .o_rs1          (o_rs1),
        .o_rs2          (o_rs2),
        .o_rd           (o_rd),
        .o_funct3       (o_funct3),
        .o_alu_res      (o_alu_res),
        .o_add_override (o_add_override),
        .o_op1_inv      (o_op1_inv),
        .o_op2_inverse  (o_op2_inverse),
        .o_op1_src      (o_op1_src),
        .o_op2_src      (o_op2_src),
        .o_res_src      (o_res_src),
        .o_reg_write    (o_reg_write),
        .o_csr_idx      (o_csr_idx),
        .o_csr_imm      (o_csr_imm),
        .o_csr_imm_sel  (o_csr_imm_sel),
        .o_csr_op       (o_csr_op)
    );

endmodule

// ==== hdl/rv_decode_reg.sv ====
`timescale 1ns/100ps

`include "rv_consts.svh"

module rv_decode_reg
    import rv_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_arst_n,
    input  logic  i_flush,

    input  logic  i_valid,
    output logic  o_ready,
    input  word_t i_instruction,
    input  pc_t   i_pc,
    input  logic  i_branch_pred,

    output logic  o_valid,
    input  logic  i_ready,
    output word_t o_instruction,
    output pc_t   o_pc,
    output pc_t   o_pc_next,
    output logic  o_branch_pred
);

    logic  valid_q;
    logic  load;
    word_t instruction_q;
    pc_t   pc_q;
    pc_t   pc_next_q;
    logic  branch_pred_q;

    // free slot, or the held item leaves this cycle
    assign o_ready = !valid_q | i_ready;
    assign load    = i_valid & o_ready & !i_flush;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (i_flush)
        begin
            valid_q <= 1'b0;
        end
        else if (o_ready)
        begin
            valid_q <= i_valid;
        end
    end

    // payload only moves on an accepted input
    always_ff @(posedge i_clk)
    begin
        if (load)
        begin
            instruction_q <= i_instruction;
            pc_q          <= i_pc;
            pc_next_q     <= i_pc + pc_t'(`RV_PC_STEP);
            branch_pred_q <= i_branch_pred;
        end
    end

    assign o_valid       = valid_q;
    assign o_instruction = instruction_q;
    assign o_pc          = pc_q;
    assign o_pc_next     = pc_next_q;
    assign o_branch_pred = branch_pred_q;

endmodule

// ==== hdl/rv_imm_gen.sv ====
`timescale 1ns/100ps

module rv_imm_gen
    import rv_pkg::*;
(
    input  word_t i_instruction,
    input  logic  i_lui,
    input  logic  i_auipc,
    input  logic  i_jal,
    input  logic  i_grp_store,
    output word_t o_imm_i,
    output word_t o_imm_j
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_u;
    word_t imm_b;
    word_t imm_j;
    logic  sign;

    assign sign = i_instruction[31];

    assign imm_i = {{21{sign}}, i_instruction[30:20]};
    assign imm_s = {{21{sign}}, i_instruction[30:25], i_instruction[11:7]};
    assign imm_u = {i_instruction[31:12], 12'b0};

    // B and J keep bit 0 at zero
    assign imm_b = {{20{sign}}, i_instruction[7], i_instruction[30:25],
                    i_instruction[11:8], 1'b0};
    assign imm_j = {{12{sign}}, i_instruction[19:12], i_instruction[20],
                    i_instruction[30:21], 1'b0};

    assign o_imm_i = (i_lui | i_auipc) ? imm_u :
                     i_grp_store       ? imm_s :
                                         imm_i;

    assign o_imm_j = i_jal ? imm_j : imm_b;

endmodule

// ==== hdl/rv_inst_class.sv ====
`timescale 1ns/100ps

`include "rv_consts.svh"

module rv_inst_class
    import rv_pkg::*;
(
    input  word_t i_instruction,

    output logic  o_grp_load,
    output logic  o_grp_store,
    output logic  o_grp_op_imm,
    output logic  o_grp_op,
    output logic  o_lui,
    output logic  o_auipc,
    output logic  o_jal,
    output logic  o_jalr,
    output logic  o_grp_branch,
    output logic  o_grp_sys,

    output logic  o_sra,
    output logic  o_ecall,
    output logic  o_ebreak,
    output logic  o_mret,
    output logic  o_csr_req,

    output logic  o_inst_supported
);

    logic [4:0]  opc;
    funct3_t     funct3;
    logic        funct7_b0;
    logic        funct7_b5;
    logic [11:0] funct12;
    logic        inst_full;
    logic        opc_op;
    logic        priv;

    assign opc       = i_instruction[6:2];
    assign funct3    = i_instruction[14:12];
    assign funct7_b0 = i_instruction[25];
    assign funct7_b5 = i_instruction[30];
    assign funct12   = i_instruction[31:20];

    assign inst_full = (i_instruction[1:0] == `RV_OPC_DET);

    assign o_grp_load   = inst_full & (opc == `RV_OPC_LOAD);
    assign o_grp_store  = inst_full & (opc == `RV_OPC_STORE);
    assign o_grp_op_imm = inst_full & (opc == `RV_OPC_OP_IMM);
    assign o_lui        = inst_full & (opc == `RV_OPC_LUI);
    assign o_auipc      = inst_full & (opc == `RV_OPC_AUIPC);
    assign o_jal        = inst_full & (opc == `RV_OPC_JAL);
    assign o_grp_branch = inst_full & (opc == `RV_OPC_BRANCH);
    assign o_grp_sys    = inst_full & (opc == `RV_OPC_SYSTEM);

    // funct7[0] set would be the M extension, not kept here
    assign opc_op   = inst_full & (opc == `RV_OPC_OP);
    assign o_grp_op = opc_op & !funct7_b0;

    assign o_jalr = inst_full & (opc == `RV_OPC_JALR) & (funct3 == 3'b000);

    // arithmetic right shift, register or immediate form
    assign o_sra = (o_grp_op | o_grp_op_imm) & (funct3 == `RV_F3_SR) & funct7_b5;

    assign priv     = o_grp_sys & (funct3 == `RV_F3_PRIV);
    assign o_ecall  = priv & (funct12 == `RV_F12_ECALL);
    assign o_ebreak = priv & (funct12 == `RV_F12_EBREAK);
    assign o_mret   = priv & (funct12 == `RV_F12_MRET);

    // every nonzero funct3 under SYSTEM is a Zicsr op
    assign o_csr_req = o_grp_sys & (funct3 != `RV_F3_PRIV);

    assign o_inst_supported = o_grp_load   |
                              o_grp_store  |
                              o_grp_op_imm |
                              o_grp_op     |
                              o_lui        |
                              o_auipc      |
                              o_jal        |
                              o_jalr       |
                              o_grp_branch |
                              o_ecall      |
                              o_ebreak     |
                              o_mret       |
                              o_csr_req;

endmodule

// ==== hdl/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]      word_t;
    typedef logic [`RV_XLEN-1:0]      pc_t;
    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`RV_CSR_IDX_W-1:0] csr_idx_t;
    typedef logic [2:0]               funct3_t;

    // result group picked at the ALU output
    typedef enum logic [1:0]
    {
        ALU_ARITH = 2'd0,
        ALU_CMP   = 2'd1,
        ALU_BITS  = 2'd2,
        ALU_SHIFT = 2'd3
    } alu_res_t;

    // second ALU operand
    typedef enum logic [1:0]
    {
        OP2_REG  = 2'd0,
        OP2_IMM  = 2'd1,
        OP2_JIMM = 2'd2
    } op2_src_t;

    // writeback source
    typedef enum logic [1:0]
    {
        RES_ALU     = 2'd0,
        RES_MEM     = 2'd1,
        RES_PC_NEXT = 2'd2
    } res_src_t;

    // matches funct3[1:0] of the Zicsr ops
    typedef enum logic [1:0]
    {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_t;

endpackage

// ==== include/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// widths
`define RV_XLEN         32
`define RV_REG_IDX_W    5
`define RV_CSR_IDX_W    12

// low two bits of every 32-bit instruction
`define RV_OPC_DET      2'b11

// major opcodes, bits 6:2
`define RV_OPC_LOAD     5'b00000
`define RV_OPC_OP_IMM   5'b00100
`define RV_OPC_AUIPC    5'b00101
`define RV_OPC_STORE    5'b01000
`define RV_OPC_OP       5'b01100
`define RV_OPC_LUI      5'b01101
`define RV_OPC_BRANCH   5'b11000
`define RV_OPC_JALR     5'b11001
`define RV_OPC_JAL      5'b11011
`define RV_OPC_SYSTEM   5'b11100

// funct3 codes of the integer ALU ops
`define RV_F3_ADD       3'b000
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_SR        3'b101
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111

// system ops
`define RV_F3_PRIV      3'b000
`define RV_F12_ECALL    12'h000
`define RV_F12_EBREAK   12'h001
`define RV_F12_MRET     12'h302

`define RV_PC_STEP      4

`endif

// ==== list.f ====
+incdir+include
hdl/rv_pkg.sv
hdl/rv_decode_reg.sv
hdl/rv_inst_class.sv
hdl/rv_imm_gen.sv
hdl/rv_ctrl_gen.sv
hdl/rv_decode.sv
testbench/tb_rv_model.sv
testbench/tb_rv_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps -f list.f --top-module tb_rv_decode \
    -o tb_rv_decode > build.log 2>&1 &&
./obj_dir/tb_rv_decode > sim.log 2>&1 ||
{ cat build.log; exit 1; }
cat sim.log
grep -q "Simulation passed" sim.log && exit 0 || exit 1

// ==== testbench/tb_rv_decode.sv ====
`timescale 1ns/100ps

module tb_rv_decode
    import rv_pkg::*, tb_rv_model::*;
();

    localparam int N_CYCLES    = 3000;
    localparam int DRAIN_LIMIT = 20;

    logic     i_clk = 1'b0;
    logic     i_arst_n;
    logic     i_flush;
    logic     i_valid;
    logic     o_ready;
    word_t    i_instruction;
    pc_t      i_pc;
    logic     i_branch_pred;
    logic     o_valid;
    logic     i_ready;
    pc_t      o_pc;
    pc_t      o_pc_next;
    logic     o_branch_pred;
    reg_idx_t o_rs1;
    reg_idx_t o_rs2;
    reg_idx_t o_rd;
    funct3_t  o_funct3;
    word_t    o_imm_i;
    word_t    o_imm_j;
    alu_res_t o_alu_res;
    logic     o_add_override;
    logic     o_op1_inv;
    logic     o_op2_inverse;
    logic     o_op1_src;
    op2_src_t o_op2_src;
    res_src_t o_res_src;
    logic     o_reg_write;
    csr_idx_t o_csr_idx;
    reg_idx_t o_csr_imm;
    logic     o_csr_imm_sel;
    csr_op_t  o_csr_op;
    logic     o_csr_req;
    logic     o_csr_ebreak;
    logic     o_inst_jal;
    logic     o_inst_jalr;
    logic     o_inst_branch;
    logic     o_inst_store;
    logic     o_inst_mret;
    logic     o_inst_ecall;
    logic     o_inst_supported;

    // items accepted by the stage, oldest first
    word_t exp_ins_q[$];
    pc_t   exp_pc_q[$];
    logic  exp_bp_q[$];
    string exp_name_q[$];

    string cur_test;
    string cur_kind_name;
    int    mismatch_count;
    int    protocol_count;
    int    timeout_count;
    int    drain_cycles;

    rv_decode UUT (.*);

    always #2 i_clk = ~i_clk;

    task automatic word_cmp(input string field, input word_t expected, input word_t actual);
        if (expected !== actual)
        begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, field, expected, actual);
        end
    endtask

    task automatic pc_cmp(input string field, input pc_t expected, input pc_t actual);
        if (expected !== actual)
        begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, field, expected, actual);
        end
    endtask

    task automatic reg_idx_cmp(input string field, input reg_idx_t expected,
                               input reg_idx_t actual);
        if (expected !== actual)
        begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, field, expected, actual);
        end
    endtask

    task automatic csr_idx_cmp(input string field, input csr_idx_t expected,
                               input csr_idx_t actual);
        if (expected !== actual)
        begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, field, expected, actual);
        end
    endtask

    task automatic funct3_cmp(input string field, input funct3_t expected, input funct3_t actual);
        if (expected !== actual)
        begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %b, actual %b", cur_test, field, expected, actual);
        end
    endtask

    task automatic alu_res_cmp(input string field, input alu_res_t expected,
                               input alu_res_t actual);
        if (expected !== actual)
        begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, field, expected, actual);
        end
    endtask

    task automatic op2_src_cmp(input string field, input op2_src_t expected,
                               input op2_src_t actual);
        if (expected !== actual)
        begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, field, expected, actual);
        end
    endtask

    task automatic res_src_cmp(input string field, input res_src_t expected,
                               input res_src_t actual);
        if (expected !== actual)
        begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, field, expected, actual);
        end
    endtask

    task automatic csr_op_cmp(input string field, input csr_op_t expected, input csr_op_t actual);
        if (expected !== actual)
        begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, field, expected, actual);
        end
    endtask

    task automatic flag_cmp(input string field, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %b, actual %b", cur_test, field, expected, actual);
        end
    endtask

    // held outputs against the oldest queued item
    task automatic check_head();
        dec_exp_t e;
        e = decode_model(exp_ins_q[0]);
        cur_test = exp_name_q[0];
        pc_cmp("pc", exp_pc_q[0], o_pc);
        pc_cmp("pc_next", exp_pc_q[0] + 32'd4, o_pc_next);
        flag_cmp("branch_pred", exp_bp_q[0], o_branch_pred);
        flag_cmp("supported", e.supported, o_inst_supported);
        flag_cmp("jal", e.jal, o_inst_jal);
        flag_cmp("jalr", e.jalr, o_inst_jalr);
        flag_cmp("branch", e.branch, o_inst_branch);
        flag_cmp("store", e.store, o_inst_store);
        flag_cmp("mret", e.mret, o_inst_mret);
        flag_cmp("ecall", e.ecall, o_inst_ecall);
        flag_cmp("ebreak", e.ebreak, o_csr_ebreak);
        flag_cmp("csr_req", e.csr_req, o_csr_req);
        reg_idx_cmp("rs1", e.rs1, o_rs1);
        reg_idx_cmp("rs2", e.rs2, o_rs2);
        reg_idx_cmp("rd", e.rd, o_rd);
        funct3_cmp("funct3", e.funct3, o_funct3);
        word_cmp("imm_i", e.imm_i, o_imm_i);
        word_cmp("imm_j", e.imm_j, o_imm_j);
        alu_res_cmp("alu_res", e.alu_res, o_alu_res);
        flag_cmp("add_override", e.add_override, o_add_override);
        flag_cmp("op1_inv", e.op1_inv, o_op1_inv);
        flag_cmp("op2_inverse", e.op2_inverse, o_op2_inverse);
        flag_cmp("op1_src", e.op1_src, o_op1_src);
        op2_src_cmp("op2_src", e.op2_src, o_op2_src);
        res_src_cmp("res_src", e.res_src, o_res_src);
        flag_cmp("reg_write", e.reg_write, o_reg_write);
        csr_idx_cmp("csr_idx", e.csr_idx, o_csr_idx);
        reg_idx_cmp("csr_imm", e.csr_imm, o_csr_imm);
        flag_cmp("csr_imm_sel", e.csr_imm_sel, o_csr_imm_sel);
        csr_op_cmp("csr_op", e.csr_op, o_csr_op);
    endtask

    task automatic drive_random_inputs();
        logic [31:0] sel;
        logic [31:0] r;
        logic [31:0] r_pc;
        int          kind;
        sel = lcg_next();
        r = lcg_next();
        r_pc = lcg_next();
        kind = int'(sel[27:24]) % NUM_KINDS;
        cur_kind_name = kind_name(kind);
        i_valid = (sel[31:30] != 2'b00);
        i_ready = (sel[29:28] != 2'b00);
        i_flush = (sel[23:20] == 4'h0);
        i_branch_pred = sel[19];
        i_pc = {r_pc[31:2], 2'b00};
        i_instruction = make_instruction(kind, r);
    endtask

    task automatic drive_idle();
        i_valid = 1'b0;
        i_ready = 1'b1;
        i_flush = 1'b0;
    endtask

    // settled values of this cycle decide what the next edge does
    task automatic sample_cycle();
        if (o_ready !== ((exp_ins_q.size() == 0) | i_ready))
        begin
            protocol_count++;
            $display("o_ready is %b while %0d items are pending and i_ready is %b",
                     o_ready, exp_ins_q.size(), i_ready);
        end
        if (o_valid !== (exp_ins_q.size() != 0))
        begin
            protocol_count++;
            $display("o_valid is %b but %0d items are pending", o_valid, exp_ins_q.size());
        end
        if (o_valid && exp_ins_q.size() != 0)
            check_head();
        if (o_valid && i_ready && exp_ins_q.size() != 0)
        begin
            void'(exp_ins_q.pop_front());
            void'(exp_pc_q.pop_front());
            void'(exp_bp_q.pop_front());
            void'(exp_name_q.pop_front());
        end
        if (i_flush)
        begin
            exp_ins_q.delete();
            exp_pc_q.delete();
            exp_bp_q.delete();
            exp_name_q.delete();
        end
        else if (i_valid && o_ready)
        begin
            exp_ins_q.push_back(i_instruction);
            exp_pc_q.push_back(i_pc);
            exp_bp_q.push_back(i_branch_pred);
            exp_name_q.push_back(cur_kind_name);
        end
    endtask

    initial
    begin
        i_arst_n = 1'b0;
        i_flush = 1'b0;
        i_valid = 1'b0;
        i_ready = 1'b0;
        i_instruction = '0;
        i_pc = '0;
        i_branch_pred = 1'b0;
        mismatch_count = 0;
        protocol_count = 0;
        timeout_count = 0;
        cur_test = "reset";
        cur_kind_name = "none";

        repeat (5) @(posedge i_clk);
        #0.5;
        i_arst_n = 1'b1;
        #1;
        if (o_valid !== 1'b0 || o_ready !== 1'b1)
        begin
            protocol_count++;
            $display("after reset o_valid is %b and o_ready is %b", o_valid, o_ready);
        end

        repeat (N_CYCLES)
        begin
            @(posedge i_clk);
            #0.5;
            drive_random_inputs();
            #1;
            sample_cycle();
        end

        // drain with the consumer always ready
        drain_cycles = 0;
        do
        begin
            @(posedge i_clk);
            #0.5;
            drive_idle();
            #1;
            sample_cycle();
            drain_cycles++;
        end
        while (exp_ins_q.size() != 0 && drain_cycles < DRAIN_LIMIT);
        if (exp_ins_q.size() != 0)
        begin
            timeout_count++;
            $display("timed out waiting for the last item to leave the stage");
        end
        @(posedge i_clk);
        #1.5;
        sample_cycle();

        $display("errors: %0d mismatches, %0d protocol, %0d timeouts",
                 mismatch_count, protocol_count, timeout_count);
        if (mismatch_count + protocol_count + timeout_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== testbench/tb_rv_model.sv ====
`include "rv_consts.svh"

package tb_rv_model;

    import rv_pkg::*;

    // expected decode of one held instruction word
    typedef struct packed
    {
        logic     supported;
        logic     jal;
        logic     jalr;
        logic     branch;
        logic     store;
        logic     mret;
        logic     ecall;
        logic     ebreak;
        logic     csr_req;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        funct3_t  funct3;
        word_t    imm_i;
        word_t    imm_j;
        alu_res_t alu_res;
        logic     add_override;
        logic     op1_inv;
        logic     op2_inverse;
        logic     op1_src;
        op2_src_t op2_src;
        res_src_t res_src;
        logic     reg_write;
        csr_idx_t csr_idx;
        reg_idx_t csr_imm;
        logic     csr_imm_sel;
        csr_op_t  csr_op;
    } dec_exp_t;

    localparam int NUM_KINDS = 15;

    logic [31:0] lcg_state = 32'h7c71;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            0:       return "load";
            1:       return "store";
            2:       return "op_imm";
            3:       return "op";
            4:       return "lui";
            5:       return "auipc";
            6:       return "jal";
            7:       return "jalr";
            8:       return "branch";
            9:       return "csr";
            10:      return "priv";
            11:      return "bad_low_bits";
            12:      return "fp_opcode";
            13:      return "m_ext";
            default: return "jalr_bad_funct3";
        endcase
    endfunction

    // kinds 0 to 10 are legal, the rest are illegal words
    function automatic word_t make_instruction(input int kind, input word_t r);
        word_t       w;
        funct3_t     f3_nz;
        logic [11:0] f12;
        logic [4:0]  fp_opc;
        f3_nz = (r[14:12] == 3'b000) ? 3'b001 : r[14:12];
        case (r[1:0])
            2'd0:    f12 = `RV_F12_ECALL;
            2'd1:    f12 = `RV_F12_EBREAK;
            default: f12 = `RV_F12_MRET;
        endcase
        // load-fp, store-fp, op-fp, fmadd
        case (r[3:2])
            2'd0:    fp_opc = 5'b00001;
            2'd1:    fp_opc = 5'b01001;
            2'd2:    fp_opc = 5'b10100;
            default: fp_opc = 5'b10000;
        endcase
        case (kind)
            0:       w = {r[31:7], `RV_OPC_LOAD, `RV_OPC_DET};
            1:       w = {r[31:7], `RV_OPC_STORE, `RV_OPC_DET};
            2:       w = {r[31:7], `RV_OPC_OP_IMM, `RV_OPC_DET};
            3:       w = {1'b0, r[30], 5'b00000, r[24:7], `RV_OPC_OP, `RV_OPC_DET};
            4:       w = {r[31:7], `RV_OPC_LUI, `RV_OPC_DET};
            5:       w = {r[31:7], `RV_OPC_AUIPC, `RV_OPC_DET};
            6:       w = {r[31:7], `RV_OPC_JAL, `RV_OPC_DET};
            7:       w = {r[31:15], 3'b000, r[11:7], `RV_OPC_JALR, `RV_OPC_DET};
            8:       w = {r[31:7], `RV_OPC_BRANCH, `RV_OPC_DET};
            9:       w = {r[31:15], f3_nz, r[11:7], `RV_OPC_SYSTEM, `RV_OPC_DET};
            10:      w = {f12, 13'h0000, `RV_OPC_SYSTEM, `RV_OPC_DET};
            11:      w = {r[31:2], 1'b0, r[4]};
            12:      w = {r[31:7], fp_opc, `RV_OPC_DET};
            13:      w = {7'b0000001, r[24:7], `RV_OPC_OP, `RV_OPC_DET};
            default: w = {r[31:15], f3_nz, r[11:7], `RV_OPC_JALR, `RV_OPC_DET};
        endcase
        return w;
    endfunction

    function automatic dec_exp_t decode_model(input word_t ins);
        dec_exp_t e;
        funct3_t  f3;
        logic     ld, st, oi, op, lui, aui, jal, jalr, br, sys;
        logic     alu, slt, sra;
        e = '0;
        f3 = ins[14:12];
        {ld, st, oi, op, lui, aui, jal, jalr, br, sys} = 10'b0;
        if (ins[1:0] == `RV_OPC_DET)
        begin
            case (ins[6:2])
                `RV_OPC_LOAD:   ld = 1'b1;
                `RV_OPC_STORE:  st = 1'b1;
                `RV_OPC_OP_IMM: oi = 1'b1;
                `RV_OPC_OP:     op = !ins[25];
                `RV_OPC_LUI:    lui = 1'b1;
                `RV_OPC_AUIPC:  aui = 1'b1;
                `RV_OPC_JAL:    jal = 1'b1;
                `RV_OPC_JALR:   jalr = (f3 == 3'b000);
                `RV_OPC_BRANCH: br = 1'b1;
                `RV_OPC_SYSTEM: sys = 1'b1;
                default:        ;
            endcase
        end
        alu = op | oi;
        slt = alu & ((f3 == `RV_F3_SLT) | (f3 == `RV_F3_SLTU));
        sra = alu & (f3 == `RV_F3_SR) & ins[30];

        e.jal = jal;
        e.jalr = jalr;
        e.branch = br;
        e.store = st;
        e.csr_req = sys & (f3 != 3'b000);
        e.ecall = sys & (f3 == 3'b000) & (ins[31:20] == `RV_F12_ECALL);
        e.ebreak = sys & (f3 == 3'b000) & (ins[31:20] == `RV_F12_EBREAK);
        e.mret = sys & (f3 == 3'b000) & (ins[31:20] == `RV_F12_MRET);
        e.supported = ld | st | oi | op | lui | aui | jal | jalr | br |
                      e.csr_req | e.ecall | e.ebreak | e.mret;

        e.rs1 = lui ? 5'd0 : ins[19:15];
        e.rs2 = ins[24:20];
        e.rd = ins[11:7];
        e.funct3 = f3;

        // U, S or I for the first immediate, J or B for the second
        if (lui | aui)
            e.imm_i = {ins[31:12], 12'h000};
        else if (st)
            e.imm_i = word_t'($signed({ins[31:25], ins[11:7]}));
        else
            e.imm_i = word_t'($signed(ins[31:20]));
        if (jal)
            e.imm_j = word_t'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
        else
            e.imm_j = word_t'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));

        if (br)
            e.alu_res = ALU_CMP;
        else if (alu)
        begin
            case (f3)
                `RV_F3_SLL, `RV_F3_SR:             e.alu_res = ALU_SHIFT;
                `RV_F3_SLT, `RV_F3_SLTU:           e.alu_res = ALU_CMP;
                `RV_F3_XOR, `RV_F3_OR, `RV_F3_AND: e.alu_res = ALU_BITS;
                default:                           e.alu_res = ALU_ARITH;
            endcase
        end

        e.add_override = lui | aui | jal | ld | st;
        e.op1_inv = br & f3[0];
        if (br | slt | sra)
            e.op2_inverse = 1'b1;
        else if (lui | aui | jal | ld | st | oi)
            e.op2_inverse = 1'b0;
        else
            e.op2_inverse = ins[30];
        e.op1_src = aui | jal;
        if (jal)
            e.op2_src = OP2_JIMM;
        else if (jalr | ld | oi | lui | aui | st)
            e.op2_src = OP2_IMM;
        else
            e.op2_src = OP2_REG;
        if (ld)
            e.res_src = RES_MEM;
        else if (jal | jalr)
            e.res_src = RES_PC_NEXT;
        else
            e.res_src = RES_ALU;
        e.reg_write = (ins[1:0] == `RV_OPC_DET) & !(br | st);

        e.csr_idx = ins[31:20];
        e.csr_imm = ins[19:15];
        e.csr_imm_sel = f3[2];
        e.csr_op = e.csr_req ? csr_op_t'(f3[1:0]) : CSR_NONE;
        return e;
    endfunction

endpackage
